//--- logic/exu_cfg_pkg.sv
////////////////////////////////////////////////////////////
// Execute stage configuration
////////////////////////////////////////////////////////////

package exu_cfg_pkg;

   // Datapath widths
   localparam int XLEN = 32;            // Integer data word
   localparam int PC_W = 31;            // PC without bit 0, halfword aligned

   // Branch history
   localparam int GHR_SIZE_DEF = 8;     // Default global history length

endpackage

//--- logic/exu_op_pkg.sv
////////////////////////////////////////////////////////////
// Execute stage opcodes and bypass sources
////////////////////////////////////////////////////////////

package exu_op_pkg;

   typedef enum logic [3:0] {
      ADD,                              // Integer ops
      SUB,
      AND,
      OR,
      XOR,
      SLT,
      SLTU,
      SLL,
      SRL,
      SRA,
      BEQ,                              // Conditional branches
      BNE,
      BLT,
      BGE,
      JAL                               // Unconditional jump, result is PC+4
   } alu_op_e;

   typedef enum logic {
      MUL_LO,                           // Low product word
      MUL_HI                            // High product word, signed x signed
   } mul_op_e;

   // Bit positions within the one-hot bypass vectors
   typedef enum logic [1:0] {
      BYP_R    = 2'd0,
      BYP_LOAD = 2'd1,
      BYP_X    = 2'd2
   } byp_src_e;

endpackage

//--- logic/exu_operand_sel.sv
////////////////////////////////////////////////////////////
// D-stage operand selection
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module exu_operand_sel (
   input  logic [exu_cfg_pkg::XLEN-1:0] i_rs1_d,           // GPR RS1
   input  logic [exu_cfg_pkg::XLEN-1:0] i_rs2_d,           // GPR RS2
   input  logic [exu_cfg_pkg::XLEN-1:0] i_imm_d,           // Decoded immediate
   input  logic [exu_cfg_pkg::PC_W-1:0] i_pc_d,            // Instruction PC
   input  logic                         i_select_pc_d,     // PC replaces RS1
   input  logic                         i_select_imm_d,    // Immediate replaces RS2
   input  logic [2:0]                   i_rs1_byp_d,       // One-hot, indexed by byp_src_e
   input  logic [2:0]                   i_rs2_byp_d,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_result_x,        // X-stage result
   input  logic [exu_cfg_pkg::XLEN-1:0] i_result_r,        // R-stage result
   input  logic [exu_cfg_pkg::XLEN-1:0] i_load_result_m,   // M-stage load data
   output logic [exu_cfg_pkg::XLEN-1:0] o_op_a,
   output logic [exu_cfg_pkg::XLEN-1:0] o_op_b,
   output logic [exu_cfg_pkg::XLEN-1:0] o_rs2_val          // RS2 without immediate
);

   localparam int XLEN = exu_cfg_pkg::XLEN;

   logic [XLEN-1:0] rs1_fwd;
   logic [XLEN-1:0] rs2_fwd;
   logic            rs1_byp_any;
   logic            rs2_byp_any;

   // AND-OR of every source enabled in the one-hot vector
   function automatic logic [XLEN-1:0] fwd_data(input logic [2:0] byp);
      logic [XLEN-1:0] data;
      data = ({XLEN{byp[exu_op_pkg::BYP_R]}}    & i_result_r)      |
             ({XLEN{byp[exu_op_pkg::BYP_LOAD]}} & i_load_result_m) |
             ({XLEN{byp[exu_op_pkg::BYP_X]}}    & i_result_x);
      return data;
   endfunction

   always_comb begin
      rs1_fwd = fwd_data(i_rs1_byp_d);
      rs2_fwd = fwd_data(i_rs2_byp_d);
   end

   assign rs1_byp_any = |i_rs1_byp_d;
   assign rs2_byp_any = |i_rs2_byp_d;

   always_comb begin
      if (rs1_byp_any) begin
         o_op_a = rs1_fwd;
      end else if (i_select_pc_d) begin
         o_op_a = {i_pc_d, 1'b0};                          // For jumps
      end else begin
         o_op_a = i_rs1_d;
      end
   end

   // Multiplier takes this one, never the immediate
   assign o_rs2_val = rs2_byp_any ? rs2_fwd : i_rs2_d;

   assign o_op_b = (!rs2_byp_any && i_select_imm_d) ? i_imm_d : o_rs2_val;

endmodule

//--- logic/exu_alu.sv
////////////////////////////////////////////////////////////
// ALU and branch resolution
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module exu_alu (
   input  logic                         clk,
   input  logic                         i_arst_n,
   input  logic                         i_x_en,            // Accept into X
   input  logic                         i_valid_d,
   input  exu_op_pkg::alu_op_e          i_alu_op_d,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_op_a,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_op_b,
   input  logic [exu_cfg_pkg::PC_W-1:0] i_pc_d,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_imm_d,           // Branch or jump offset
   input  logic                         i_pred_taken_d,
   output logic [exu_cfg_pkg::XLEN-1:0] o_alu_result_x,
   output logic [exu_cfg_pkg::PC_W-1:0] o_pc_x,
   output logic                         o_branch_d,        // Valid branch or jump
   output logic                         o_taken_d,         // Actual direction
   output logic                         o_flush_upper_d,   // Mispredict at D
   output logic [exu_cfg_pkg::PC_W-1:0] o_flush_path_d     // Correct path
);

   localparam int XLEN = exu_cfg_pkg::XLEN;
   localparam int PC_W = exu_cfg_pkg::PC_W;

   logic [XLEN-1:0] result_d;
   logic [PC_W-1:0] pc_plus4;
   logic [PC_W-1:0] target;
   logic            eq;
   logic            lt;
   logic            is_br;
   logic            actual_taken;

   assign eq       = (i_op_a == i_op_b);
   assign lt       = ($signed(i_op_a) < $signed(i_op_b));
   assign pc_plus4 = i_pc_d + PC_W'(2);                    // Halfword units
   assign target   = i_pc_d + i_imm_d[XLEN-1:1];

   always_comb begin
      result_d     = '0;
      is_br        = 1'b0;
      actual_taken = 1'b0;
      case (i_alu_op_d)
         exu_op_pkg::ADD:  result_d = i_op_a + i_op_b;
         exu_op_pkg::SUB:  result_d = i_op_a - i_op_b;
         exu_op_pkg::AND:  result_d = i_op_a & i_op_b;
         exu_op_pkg::OR:   result_d = i_op_a | i_op_b;
         exu_op_pkg::XOR:  result_d = i_op_a ^ i_op_b;
         exu_op_pkg::SLT:  result_d = {{(XLEN-1){1'b0}}, lt};
         exu_op_pkg::SLTU: result_d = {{(XLEN-1){1'b0}}, (i_op_a < i_op_b)};
         exu_op_pkg::SLL:  result_d = i_op_a << i_op_b[4:0];
         exu_op_pkg::SRL:  result_d = i_op_a >> i_op_b[4:0];
         exu_op_pkg::SRA:  result_d = $signed(i_op_a) >>> i_op_b[4:0];
         exu_op_pkg::BEQ: begin
            is_br        = 1'b1;
            actual_taken = eq;
         end
         exu_op_pkg::BNE: begin
            is_br        = 1'b1;
            actual_taken = !eq;
         end
         exu_op_pkg::BLT: begin
            is_br        = 1'b1;
            actual_taken = lt;
         end
         exu_op_pkg::BGE: begin
            is_br        = 1'b1;
            actual_taken = !lt;
         end
         exu_op_pkg::JAL: begin
            is_br        = 1'b1;
            actual_taken = 1'b1;
            result_d     = {i_pc_d, 1'b0} + XLEN'(4);      // Link address
         end
         default: result_d = '0;
      endcase
   end

   assign o_branch_d      = i_valid_d & is_br;
   assign o_taken_d       = o_branch_d & actual_taken;
   assign o_flush_upper_d = o_branch_d & (actual_taken != i_pred_taken_d);
   assign o_flush_path_d  = actual_taken ? target : pc_plus4;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_alu_result_x <= '0;
         o_pc_x         <= '0;
      end else if (i_x_en) begin
         o_alu_result_x <= result_d;
         o_pc_x         <= i_pc_d;
      end
   end

endmodule

//--- logic/exu_mul.sv
////////////////////////////////////////////////////////////
// Signed multiplier
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module exu_mul (
   input  logic                         clk,
   input  logic                         i_arst_n,
   input  logic                         i_x_en,            // Accept into X
   input  logic                         i_mul_d,           // Multiply in D
   input  exu_op_pkg::mul_op_e          i_mul_op_d,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_op_a,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_rs2_val,
   output logic [exu_cfg_pkg::XLEN-1:0] o_mul_result_x
);

   localparam int XLEN = exu_cfg_pkg::XLEN;

   logic signed [XLEN-1:0]   a_s;
   logic signed [XLEN-1:0]   b_s;
   logic signed [2*XLEN-1:0] prod;

   // Quiet the array when no multiply is in D
   assign a_s  = i_op_a    & {XLEN{i_mul_d}};
   assign b_s  = i_rs2_val & {XLEN{i_mul_d}};
   assign prod = (2*XLEN)'(a_s) * (2*XLEN)'(b_s);          // Sign extended to full width

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_mul_result_x <= '0;
      end else if (i_x_en) begin
         if (i_mul_op_d == exu_op_pkg::MUL_HI) begin
            o_mul_result_x <= prod[2*XLEN-1:XLEN];
         end else begin
            o_mul_result_x <= prod[XLEN-1:0];
         end
      end
   end

endmodule

//--- logic/exu_ctl.sv
////////////////////////////////////////////////////////////
// Execute stage control and branch history
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module exu_ctl #(
   parameter int GHR_SIZE = exu_cfg_pkg::GHR_SIZE_DEF
) (
   input  logic                         clk,
   input  logic                         i_arst_n,
   input  logic                         i_valid_d,
   input  logic                         i_mul_d,
   input  logic                         i_branch_d,        // Valid branch or jump at D
   input  logic                         i_taken_d,
   input  logic                         i_flush_upper_d,   // D-stage mispredict
   input  logic [exu_cfg_pkg::PC_W-1:0] i_flush_path_d,
   input  logic                         i_flush_lower_r,   // Older flush from R
   input  logic [exu_cfg_pkg::PC_W-1:0] i_flush_path_r,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_alu_result_x,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_mul_result_x,
   output logic                         o_x_en,
   output logic [exu_cfg_pkg::XLEN-1:0] o_result_x,
   output logic                         o_valid_x,
   output logic                         o_flush_final,
   output logic [exu_cfg_pkg::PC_W-1:0] o_flush_path_final,
   output logic [GHR_SIZE-1:0]          o_ghr_d,
   output logic                         o_mp_valid_x,
   output logic [GHR_SIZE-1:0]          o_mp_ghr_x
);

   logic                mul_x;
   logic                branch_x;
   logic                taken_x;
   logic [GHR_SIZE-1:0] ghr_d;
   logic [GHR_SIZE-1:0] ghr_d_ns;
   logic [GHR_SIZE-1:0] ghr_x;
   logic [GHR_SIZE-1:0] ghr_x_ns;

   assign o_x_en = i_valid_d & ~i_flush_lower_r;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_valid_x    <= 1'b0;
         o_mp_valid_x <= 1'b0;
         mul_x        <= 1'b0;
         branch_x     <= 1'b0;
         taken_x      <= 1'b0;
      end else begin
         o_valid_x    <= o_x_en;
         o_mp_valid_x <= o_x_en & i_flush_upper_d;
         branch_x     <= o_x_en & i_branch_d;
         taken_x      <= o_x_en & i_taken_d;
         if (o_x_en) begin
            mul_x <= i_mul_d;                              // Holds X result select
         end
      end
   end

   // D history, restored from X on an older flush
   always_comb begin
      if (i_flush_lower_r) begin
         ghr_d_ns = ghr_x;
      end else if (i_branch_d) begin
         ghr_d_ns = {ghr_d[GHR_SIZE-2:0], i_taken_d};
      end else begin
         ghr_d_ns = ghr_d;
      end
   end

   assign ghr_x_ns = branch_x ? {ghr_x[GHR_SIZE-2:0], taken_x} : ghr_x;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ghr_d <= '0;
         ghr_x <= '0;
      end else begin
         ghr_d <= ghr_d_ns;
         ghr_x <= ghr_x_ns;
      end
   end

   assign o_ghr_d    = ghr_d;
   assign o_mp_ghr_x = o_mp_valid_x ? ghr_d : ghr_x;       // Mispredict sees D history

   // Older R-stage flush wins
   assign o_flush_final      = i_flush_lower_r | i_flush_upper_d;
   assign o_flush_path_final =
      ({exu_cfg_pkg::PC_W{i_flush_lower_r}}                    & i_flush_path_r) |
      ({exu_cfg_pkg::PC_W{~i_flush_lower_r & i_flush_upper_d}} & i_flush_path_d);

   assign o_result_x = mul_x ? i_mul_result_x : i_alu_result_x;

endmodule

//--- logic/exu_top.sv
////////////////////////////////////////////////////////////
// Integer execute stage
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module exu_top #(
   parameter int GHR_SIZE = exu_cfg_pkg::GHR_SIZE_DEF
) (
   input  logic                         clk,
   input  logic                         i_arst_n,
   input  logic                         i_valid_d,
   input  exu_op_pkg::alu_op_e          i_alu_op_d,
   input  logic                         i_mul_d,
   input  exu_op_pkg::mul_op_e          i_mul_op_d,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_rs1_d,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_rs2_d,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_imm_d,
   input  logic                         i_select_imm_d,
   input  logic [exu_cfg_pkg::PC_W-1:0] i_pc_d,
   input  logic                         i_select_pc_d,
   input  logic [2:0]                   i_rs1_byp_d,
   input  logic [2:0]                   i_rs2_byp_d,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_result_r,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_load_result_m,
   input  logic                         i_pred_taken_d,
   input  logic                         i_flush_lower_r,
   input  logic [exu_cfg_pkg::PC_W-1:0] i_flush_path_r,
   output logic [exu_cfg_pkg::XLEN-1:0] o_result_x,
   output logic                         o_valid_x,
   output logic [exu_cfg_pkg::PC_W-1:0] o_pc_x,
   output logic                         o_flush_final,
   output logic [exu_cfg_pkg::PC_W-1:0] o_flush_path_final,
   output logic [GHR_SIZE-1:0]          o_ghr_d,
   output logic                         o_mp_valid_x,
   output logic [GHR_SIZE-1:0]          o_mp_ghr_x
);

   logic [exu_cfg_pkg::XLEN-1:0] op_a;
   logic [exu_cfg_pkg::XLEN-1:0] op_b;
   logic [exu_cfg_pkg::XLEN-1:0] rs2_val;
   logic [exu_cfg_pkg::XLEN-1:0] alu_result_x;
   logic [exu_cfg_pkg::XLEN-1:0] mul_result_x;
   logic [exu_cfg_pkg::PC_W-1:0] flush_path_d;
   logic                         x_en;
   logic                         branch_d;
   logic                         taken_d;
   logic                         flush_upper_d;

   exu_operand_sel exu_operand_sel_inst (
      .i_rs1_d         (i_rs1_d),
      .i_rs2_d         (i_rs2_d),
      .i_imm_d         (i_imm_d),
      .i_pc_d          (i_pc_d),
      .i_select_pc_d   (i_select_pc_d),
      .i_select_imm_d  (i_select_imm_d),
      .i_rs1_byp_d     (i_rs1_byp_d),
      .i_rs2_byp_d     (i_rs2_byp_d),
      .i_result_x      (o_result_x),                       // BYP_X path
      .i_result_r      (i_result_r),
      .i_load_result_m (i_load_result_m),
      .o_op_a          (op_a),
      .o_op_b          (op_b),
      .o_rs2_val       (rs2_val)
   );

   exu_alu exu_alu_inst (
      .clk             (clk),
      .i_arst_n        (i_arst_n),
      .i_x_en          (x_en),
      .i_valid_d       (i_valid_d),
      .i_alu_op_d      (i_alu_op_d),
      .i_op_a          (op_a),
      .i_op_b          (op_b),
      .i_pc_d          (i_pc_d),
      .i_imm_d         (i_imm_d),
      .i_pred_taken_d  (i_pred_taken_d),
      .o_alu_result_x  (alu_result_x),
      .o_pc_x          (o_pc_x),
      .o_branch_d      (branch_d),
      .o_taken_d       (taken_d),
      .o_flush_upper_d (flush_upper_d),
      .o_flush_path_d  (flush_path_d)
   );

   exu_mul exu_mul_inst (
      .clk             (clk),
      .i_arst_n        (i_arst_n),
      .i_x_en          (x_en),
      .i_mul_d         (i_mul_d),
      .i_mul_op_d      (i_mul_op_d),
      .i_op_a          (op_a),
      .i_rs2_val       (rs2_val),
      .o_mul_result_x  (mul_result_x)
   );

   exu_ctl #(
      .GHR_SIZE (GHR_SIZE)
   ) exu_ctl_inst (
      .clk                (clk),
      .i_arst_n           (i_arst_n),
      .i_valid_d          (i_valid_d),
      .i_mul_d            (i_mul_d),
      .i_branch_d         (branch_d),
      .i_taken_d          (taken_d),
      .i_flush_upper_d    (flush_upper_d),
      .i_flush_path_d     (flush_path_d),
      .i_flush_lower_r    (i_flush_lower_r),
      .i_flush_path_r     (i_flush_path_r),
      .i_alu_result_x     (alu_result_x),
      .i_mul_result_x     (mul_result_x),
      .o_x_en             (x_en),
      .o_result_x         (o_result_x),
      .o_valid_x          (o_valid_x),
      .o_flush_final      (o_flush_final),
      .o_flush_path_final (o_flush_path_final),
      .o_ghr_d            (o_ghr_d),
      .o_mp_valid_x       (o_mp_valid_x),
      .o_mp_ghr_x         (o_mp_ghr_x)
   );

endmodule

//--- dv/exu_assertions.sv
////////////////////////////////////////////////////////////
// Execute control checks
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module exu_assertions (
   input logic                         clk,
   input logic                         i_arst_n,
   input logic                         i_x_en,
   input logic                         i_valid_x,
   input logic                         i_flush_upper_d,
   input logic                         i_flush_lower_r,
   input logic [exu_cfg_pkg::PC_W-1:0] i_flush_path_r,
   input logic                         i_flush_final,
   input logic [exu_cfg_pkg::PC_W-1:0] i_flush_path_final,
   input logic                         i_mp_valid_x
);

   valid_in_reset: assert property (@(posedge clk) !i_arst_n |-> !i_valid_x)
      else $error("X valid high while reset is applied");

   // Older R-stage flush owns the redirect
   older_flush_wins: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_flush_lower_r |-> (i_flush_final && (i_flush_path_final == i_flush_path_r)))
      else $error("older flush did not select its own path");

   mp_follows_flush: assert property (@(posedge clk) disable iff (!i_arst_n)
      (i_x_en && i_flush_upper_d) |=> i_mp_valid_x)
      else $error("mispredict valid missing one cycle after an accepted mispredict");

endmodule

bind exu_ctl exu_assertions exu_assertions_inst (
   .clk                (clk),
   .i_arst_n           (i_arst_n),
   .i_x_en             (o_x_en),
   .i_valid_x          (o_valid_x),
   .i_flush_upper_d    (i_flush_upper_d),
   .i_flush_lower_r    (i_flush_lower_r),
   .i_flush_path_r     (i_flush_path_r),
   .i_flush_final      (o_flush_final),
   .i_flush_path_final (o_flush_path_final),
   .i_mp_valid_x       (o_mp_valid_x)
);

//--- dv/exu_tb.sv
////////////////////////////////////////////////////////////
// Execute stage testbench
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module exu_tb;

   localparam int XLEN  = exu_cfg_pkg::XLEN;
   localparam int PC_W  = exu_cfg_pkg::PC_W;
   localparam int GHR   = exu_cfg_pkg::GHR_SIZE_DEF;
   localparam int NROWS = 24;
   localparam logic [PC_W-1:0] R_PATH = 31'h1234;          // Older flush target

   typedef struct packed {
      exu_op_pkg::alu_op_e op;
      logic [1:0]          mul;                            // {multiply, high word}
      logic [5:0]          flags;                          // {rnd, pc, imm, pred, flush_r, flush}
      logic [2:0]          byp1;
      logic [2:0]          byp2;
      logic [XLEN-1:0]     rs1;
      logic [XLEN-1:0]     rs2;
      logic [XLEN-1:0]     imm;
      logic [PC_W-1:0]     path;                           // Expected flush path
   } row_t;

   // Row i sits at halfword PC 0x400 + 2*i
   row_t rows [NROWS] = '{
      '{exu_op_pkg::ADD,  2'b00, 6'b100000, 3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 31'h0},
      '{exu_op_pkg::SUB,  2'b00, 6'b100000, 3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 31'h0},
      '{exu_op_pkg::AND,  2'b00, 6'b100000, 3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 31'h0},
      '{exu_op_pkg::OR,   2'b00, 6'b100000, 3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 31'h0},
      '{exu_op_pkg::XOR,  2'b00, 6'b100000, 3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 31'h0},
      '{exu_op_pkg::SLT,  2'b00, 6'b100000, 3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 31'h0},
      '{exu_op_pkg::SLTU, 2'b00, 6'b100000, 3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 31'h0},
      '{exu_op_pkg::SLL,  2'b00, 6'b100000, 3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 31'h0},
      '{exu_op_pkg::SRL,  2'b00, 6'b100000, 3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 31'h0},
      '{exu_op_pkg::SRA,  2'b00, 6'b100000, 3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 31'h0},
      // Bypass sources and PC or immediate selects
      '{exu_op_pkg::ADD,  2'b00, 6'b000000, 3'b100, 3'b001, 32'h0, 32'h0, 32'h0, 31'h0},
      '{exu_op_pkg::SUB,  2'b00, 6'b001000, 3'b010, 3'b000, 32'h0, 32'h0, 32'h64, 31'h0},
      '{exu_op_pkg::ADD,  2'b00, 6'b011000, 3'b000, 3'b000, 32'h0, 32'h0, 32'h10, 31'h0},
      // Multiplies, the first one with an immediate that it must ignore
      '{exu_op_pkg::ADD,  2'b10, 6'b101000, 3'b000, 3'b000, 32'h0, 32'h0, 32'h7, 31'h0},
      '{exu_op_pkg::ADD,  2'b11, 6'b100000, 3'b000, 3'b100, 32'h0, 32'h0, 32'h0, 31'h0},
      '{exu_op_pkg::XOR,  2'b00, 6'b100000, 3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 31'h0},
      // Branches and jumps in every predicted and actual direction
      '{exu_op_pkg::BEQ,  2'b00, 6'b000100, 3'b000, 3'b000, 32'h5, 32'h5, 32'h40, 31'h0},
      '{exu_op_pkg::BNE,  2'b00, 6'b000101, 3'b000, 3'b000, 32'h5, 32'h5, 32'h40, 31'h424},
      '{exu_op_pkg::BLT,  2'b00, 6'b000001, 3'b000, 3'b000, '1, 32'h1, 32'h40, 31'h444},
      '{exu_op_pkg::BGE,  2'b00, 6'b000000, 3'b000, 3'b000, '1, 32'h1, 32'h40, 31'h0},
      '{exu_op_pkg::JAL,  2'b00, 6'b000001, 3'b000, 3'b000, 32'h0, 32'h0, 32'h100, 31'h4a8},
      '{exu_op_pkg::JAL,  2'b00, 6'b000100, 3'b000, 3'b000, 32'h0, 32'h0, 32'h100, 31'h0},
      '{exu_op_pkg::BEQ,  2'b00, 6'b000011, 3'b000, 3'b000, 32'h7, 32'h7, 32'h40, R_PATH},
      '{exu_op_pkg::ADD,  2'b00, 6'b100000, 3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 31'h0}
   };

   logic                clk;
   logic                i_arst_n;
   logic                i_valid_d;
   exu_op_pkg::alu_op_e i_alu_op_d;
   logic                i_mul_d;
   exu_op_pkg::mul_op_e i_mul_op_d;
   logic [XLEN-1:0]     i_rs1_d, i_rs2_d, i_imm_d, i_result_r, i_load_result_m;
   logic [PC_W-1:0]     i_pc_d, i_flush_path_r;
   logic                i_select_imm_d, i_select_pc_d, i_pred_taken_d, i_flush_lower_r;
   logic [2:0]          i_rs1_byp_d, i_rs2_byp_d;
   logic [XLEN-1:0]     o_result_x;
   logic [PC_W-1:0]     o_pc_x, o_flush_path_final;
   logic                o_valid_x, o_flush_final, o_mp_valid_x;
   logic [GHR-1:0]      o_ghr_d, o_mp_ghr_x;

   logic [GHR-1:0]      m_ghr_d, m_ghr_x;                  // History model
   logic                m_pend_br, m_pend_tk;              // Branch waiting for X history
   logic [XLEN-1:0]     last_res, exp_res;
   logic [PC_W-1:0]     exp_pc;
   logic                exp_acc, exp_mp, exp_chk;

   exu_top #(.GHR_SIZE(GHR)) exu_top_inst (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic stop_run();
      $display("Test failures found");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_word(input string name, input logic [XLEN-1:0] got, want);
      if (got !== want) begin
         $display("error: %s = 0x%h, expected 0x%h", name, got, want);
         stop_run();
      end
   endtask

   task automatic check_pc(input string name, input logic [PC_W-1:0] got, want);
      if (got !== want) begin
         $display("error: %s = 0x%h, expected 0x%h", name, got, want);
         stop_run();
      end
   endtask

   task automatic check_flag(input string name, input logic got, want);
      if (got !== want) begin
         $display("error: %s = 0x%h, expected 0x%h", name, got, want);
         stop_run();
      end
   endtask

   task automatic check_ghr(input string name, input logic [GHR-1:0] got, want);
      if (got !== want) begin
         $display("error: %s = 0x%h, expected 0x%h", name, got, want);
         stop_run();
      end
   endtask

   task automatic wait_valid_x();
      int n;
      n = 0;
      while (o_valid_x !== 1'b1) begin
         if (n == 4) begin
            $display("o_valid_x never rose after an accepted instruction");
            stop_run();
         end
         n++;
         @(negedge clk);
      end
   endtask

   function automatic logic [XLEN-1:0] fwd_value(input logic [2:0] byp,
                                                 input logic [XLEN-1:0] r, ld);
      case (byp)
         3'b001:  return r;                                // BYP_R
         3'b010:  return ld;                               // BYP_LOAD
         3'b100:  return last_res;                         // BYP_X
         default: return '0;
      endcase
   endfunction

   function automatic logic [XLEN-1:0] alu_model(input exu_op_pkg::alu_op_e op,
                                                 input logic [XLEN-1:0] a, b,
                                                 input logic [PC_W-1:0] pc);
      case (op)
         exu_op_pkg::ADD:  return a + b;
         exu_op_pkg::SUB:  return a - b;
         exu_op_pkg::AND:  return a & b;
         exu_op_pkg::OR:   return a | b;
         exu_op_pkg::XOR:  return a ^ b;
         exu_op_pkg::SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         exu_op_pkg::SLTU: return (a < b) ? 32'd1 : 32'd0;
         exu_op_pkg::SLL:  return a << b[4:0];
         exu_op_pkg::SRL:  return a >> b[4:0];
         exu_op_pkg::SRA:  return $signed(a) >>> b[4:0];
         exu_op_pkg::JAL:  return {pc, 1'b0} + 32'd4;     // Link address
         default:          return '0;
      endcase
   endfunction

   function automatic logic taken_model(input exu_op_pkg::alu_op_e op,
                                        input logic [XLEN-1:0] a, b);
      case (op)
         exu_op_pkg::BEQ: return a == b;
         exu_op_pkg::BNE: return a != b;
         exu_op_pkg::BLT: return $signed(a) < $signed(b);
         exu_op_pkg::BGE: return !($signed(a) < $signed(b));
         exu_op_pkg::JAL: return 1'b1;
         default:         return 1'b0;
      endcase
   endfunction

   // Drive one row, check the D-stage flush and advance the model by one edge
   task automatic apply_row(input int i);
      row_t                     r;
      logic [XLEN-1:0]          r_val, ld_val, a, b_reg, b;
      logic signed [2*XLEN-1:0] sa, sb, prod;
      logic                     br, tk;
      r               = rows[i];
      r_val           = $urandom;
      ld_val          = $urandom;
      i_rs1_d         = r.flags[5] ? $urandom : r.rs1;
      i_rs2_d         = r.flags[5] ? $urandom : r.rs2;
      i_alu_op_d      = r.op;
      i_mul_d         = r.mul[1];
      i_mul_op_d      = exu_op_pkg::mul_op_e'(r.mul[0]);
      i_imm_d         = r.imm;
      i_pc_d          = 31'h400 + PC_W'(2 * i);
      i_select_pc_d   = r.flags[4];
      i_select_imm_d  = r.flags[3];
      i_pred_taken_d  = r.flags[2];
      i_flush_lower_r = r.flags[1];
      i_rs1_byp_d     = r.byp1;
      i_rs2_byp_d     = r.byp2;
      i_result_r      = r_val;
      i_load_result_m = ld_val;
      i_valid_d       = 1'b1;
      a     = (|r.byp1) ? fwd_value(r.byp1, r_val, ld_val) :
              (r.flags[4] ? {i_pc_d, 1'b0} : i_rs1_d);
      b_reg = (|r.byp2) ? fwd_value(r.byp2, r_val, ld_val) : i_rs2_d;
      b     = (!(|r.byp2) && r.flags[3]) ? r.imm : b_reg;
      br    = r.op inside {exu_op_pkg::BEQ, exu_op_pkg::BNE, exu_op_pkg::BLT,
                           exu_op_pkg::BGE, exu_op_pkg::JAL};
      tk    = taken_model(r.op, a, b);
      #2;
      check_flag("o_flush_final", o_flush_final, r.flags[0]);
      if (r.flags[0]) begin
         check_pc("o_flush_path_final", o_flush_path_final, r.path);
      end
      sa      = (2*XLEN)'($signed(a));
      sb      = (2*XLEN)'($signed(b_reg));                 // Multiplier never sees the immediate
      prod    = sa * sb;
      exp_acc = !r.flags[1];
      exp_mp  = exp_acc && br && (tk != r.flags[2]);
      exp_chk = !br || (r.op == exu_op_pkg::JAL);
      exp_pc  = i_pc_d;
      if (r.mul[1]) begin
         exp_res = r.mul[0] ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
      end else begin
         exp_res = alu_model(r.op, a, b, i_pc_d);
      end
      if (exp_acc) begin
         last_res = exp_res;
      end
      if (r.flags[1]) begin
         m_ghr_d = m_ghr_x;                                // Recover from X history
      end else if (br) begin
         m_ghr_d = {m_ghr_d[GHR-2:0], tk};
      end
      if (m_pend_br) begin
         m_ghr_x = {m_ghr_x[GHR-2:0], m_pend_tk};
      end
      m_pend_br = exp_acc && br;
      m_pend_tk = tk;
   endtask

   task automatic verify_x_stage();
      check_ghr("o_ghr_d", o_ghr_d, m_ghr_d);
      if (exp_acc) begin
         wait_valid_x();
         if (exp_chk) begin
            check_word("o_result_x", o_result_x, exp_res);
         end
         check_pc("o_pc_x", o_pc_x, exp_pc);
      end else begin
         check_flag("o_valid_x", o_valid_x, 1'b0);
      end
      check_flag("o_mp_valid_x", o_mp_valid_x, exp_mp);
      check_ghr("o_mp_ghr_x", o_mp_ghr_x, exp_mp ? m_ghr_d : m_ghr_x);
   endtask

   initial begin
      void'($urandom(32'h490e3959));
      i_arst_n        = 1'b0;
      i_valid_d       = 1'b0;
      i_alu_op_d      = exu_op_pkg::ADD;
      i_mul_d         = 1'b0;
      i_mul_op_d      = exu_op_pkg::MUL_LO;
      i_rs1_d         = '0;
      i_rs2_d         = '0;
      i_imm_d         = '0;
      i_result_r      = '0;
      i_load_result_m = '0;
      i_pc_d          = '0;
      i_flush_path_r  = R_PATH;
      i_select_imm_d  = 1'b0;
      i_select_pc_d   = 1'b0;
      i_pred_taken_d  = 1'b0;
      i_flush_lower_r = 1'b0;
      i_rs1_byp_d     = '0;
      i_rs2_byp_d     = '0;
      m_ghr_d         = '0;
      m_ghr_x         = '0;
      m_pend_br       = 1'b0;
      m_pend_tk       = 1'b0;
      last_res        = '0;
      repeat (2) @(negedge clk);
      check_flag("o_valid_x", o_valid_x, 1'b0);
      check_flag("o_flush_final", o_flush_final, 1'b0);
      check_flag("o_mp_valid_x", o_mp_valid_x, 1'b0);
      check_ghr("o_ghr_d", o_ghr_d, '0);
      check_ghr("o_mp_ghr_x", o_mp_ghr_x, '0);
      i_arst_n = 1'b1;
      for (int i = 0; i < NROWS; i++) begin
         @(negedge clk);
         if (i > 0) begin
            verify_x_stage();                              // Previous row, now in X
         end
         apply_row(i);
      end
      @(negedge clk);
      verify_x_stage();
      i_valid_d = 1'b0;
      $display("All tests passed!");
      $finish;
   end

endmodule

//--- sources.f
logic/exu_cfg_pkg.sv
logic/exu_op_pkg.sv
logic/exu_operand_sel.sv
logic/exu_alu.sv
logic/exu_mul.sv
logic/exu_ctl.sv
logic/exu_top.sv
dv/exu_assertions.sv
dv/exu_tb.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module exu_tb -f sources.f \
		--Mdir $(OBJ_DIR) -o exu_tb

run: compile
	./$(OBJ_DIR)/exu_tb

clean:
	rm -rf $(OBJ_DIR)
